//--- rio_pkg.sv
// Host-side register map of the remote I/O controller.
// Shared by the AXI4-Lite register block and the top level.
package rio_pkg;

    // Register data and byte address as seen by the host
    typedef logic [31:0] reg_word_t;
    typedef logic [7:0]  reg_addr_t;

    // Write side, shadow registers and commit
    localparam reg_addr_t ADDR_CTRL   = 8'h00;
    localparam reg_addr_t ADDR_VEL0   = 8'h04;
    localparam reg_addr_t ADDR_VEL1   = 8'h08;
    localparam reg_addr_t ADDR_VEL2   = 8'h0C;
    localparam reg_addr_t ADDR_COMMIT = 8'h10;

    // Bits 0 to 2 of CTRL enable the axes
    localparam int CTRL_OUT_BIT = 3;

    // Read side
    localparam reg_addr_t ADDR_MAGIC  = 8'h00;
    localparam reg_addr_t ADDR_TSTAMP = 8'h04;
    localparam reg_addr_t ADDR_POS0   = 8'h08;
    localparam reg_addr_t ADDR_POS1   = 8'h0C;
    localparam reg_addr_t ADDR_POS2   = 8'h10;
    localparam reg_addr_t ADDR_STATUS = 8'h14;

    // Bits 0 to 2 of STATUS carry the home inputs
    localparam int STATUS_TIMEOUT_BIT = 4;

    // ASCII "data", lets the host recognise the board
    localparam reg_word_t MAGIC_WORD = 32'h6461_7461;

    // AXI response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

//--- motion_pkg.sv
// Types for the step/direction generators.
// Axis count, velocity and position words, generator FSM states.
package motion_pkg;

    localparam int NUM_AXES = 3;

    // Sign picks the direction, magnitude sets the step rate
    typedef logic signed [31:0] velocity_t;

    // Signed step count per axis
    typedef logic signed [31:0] position_t;

    typedef enum logic [1:0] {
        IDLE,
        DIR_SETUP,
        PULSE,
        SPACE
    } dir_state_e;

endpackage

//--- host_regs.sv
// AXI4-Lite register block facing the host.
// Command words go to shadow registers and become live together
// on a write to the commit register; reads return status and positions.
`timescale 1ns/1ps

module host_regs import rio_pkg::*, motion_pkg::*; (
    input  logic                sysclk,
    input  logic                arst_n,
    input  reg_addr_t           awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  reg_word_t           wdata,
    // Byte strobes are not decoded, full-word writes only
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  reg_addr_t           araddr,
    input  logic                arvalid,
    output logic                arready,
    output reg_word_t           rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  reg_word_t           tstamp,
    input  position_t           pos0,
    input  position_t           pos1,
    input  position_t           pos2,
    input  logic [NUM_AXES-1:0] inputs,
    input  logic                timeout,
    output velocity_t           vel0,
    output velocity_t           vel1,
    output velocity_t           vel2,
    output logic [NUM_AXES-1:0] axis_en,
    output logic                out_bit,
    output logic                commit
);

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_mapped;
    logic                  rd_mapped;
    reg_word_t             rd_word;
    logic [CTRL_OUT_BIT:0] ctrl_shadow;
    velocity_t             vel0_shadow;
    velocity_t             vel1_shadow;
    velocity_t             vel2_shadow;

    // One request of each kind in flight
    assign wr_fire = awvalid & wvalid & ~bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rd_fire = arvalid & ~rvalid;
    assign arready = rd_fire;

    always_comb begin
        case (awaddr)
            ADDR_CTRL, ADDR_VEL0, ADDR_VEL1, ADDR_VEL2, ADDR_COMMIT: wr_mapped = 1'b1;
            default: wr_mapped = 1'b0;
        endcase
    end

    always_comb begin
        rd_mapped = 1'b1;
        case (araddr)
            ADDR_MAGIC:  rd_word = MAGIC_WORD;
            ADDR_TSTAMP: rd_word = tstamp;
            ADDR_POS0:   rd_word = reg_word_t'(pos0);
            ADDR_POS1:   rd_word = reg_word_t'(pos1);
            ADDR_POS2:   rd_word = reg_word_t'(pos2);
            ADDR_STATUS: begin
                rd_word = '0;
                rd_word[NUM_AXES-1:0] = inputs;
                rd_word[STATUS_TIMEOUT_BIT] = timeout;
            end
            default: begin
                rd_word   = '0;
                rd_mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            commit      <= 1'b0;
            ctrl_shadow <= '0;
            vel0_shadow <= '0;
            vel1_shadow <= '0;
            vel2_shadow <= '0;
            vel0        <= '0;
            vel1        <= '0;
            vel2        <= '0;
            axis_en     <= '0;
            out_bit     <= 1'b0;
        end else begin
            commit <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                case (awaddr)
                    ADDR_CTRL: ctrl_shadow <= wdata[CTRL_OUT_BIT:0];
                    ADDR_VEL0: vel0_shadow <= velocity_t'(wdata);
                    ADDR_VEL1: vel1_shadow <= velocity_t'(wdata);
                    ADDR_VEL2: vel2_shadow <= velocity_t'(wdata);
                    ADDR_COMMIT: begin
                        // All command values go live in the same cycle
                        commit  <= 1'b1;
                        vel0    <= vel0_shadow;
                        vel1    <= vel1_shadow;
                        vel2    <= vel2_shadow;
                        axis_en <= ctrl_shadow[NUM_AXES-1:0];
                        out_bit <= ctrl_shadow[CTRL_OUT_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Response payloads, only sampled while the matching valid is high
    always_ff @(posedge sysclk) begin
        if (wr_fire) begin
            bresp <= wr_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

endmodule

//--- link_watchdog.sv
// Host link supervision and time base.
// Raises timeout when no commit arrives for TIMEOUT cycles and
// keeps a free-running cycle timestamp for the host.
`timescale 1ns/1ps

module link_watchdog import rio_pkg::*; #(
    parameter int TIMEOUT = 2700000
) (
    input  logic      sysclk,
    input  logic      arst_n,
    input  logic      commit,
    output logic      timeout,
    output reg_word_t tstamp
);

    localparam int CNT_BITS = $clog2(TIMEOUT + 1);

    logic [CNT_BITS-1:0] idle_cnt;

    // Saturates at TIMEOUT until the next commit
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            idle_cnt <= '0;
        end else if (commit) begin
            idle_cnt <= '0;
        end else if (!timeout) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign timeout = (idle_cnt == CNT_BITS'(TIMEOUT));

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tstamp <= '0;
        end else begin
            tstamp <= tstamp + 1'b1;
        end
    end

endmodule

//--- stepgen.sv
// Step/direction generator for one axis.
// A phase accumulator turns the velocity magnitude into step requests;
// the FSM adds direction setup time, fixed pulse width and spacing.
`timescale 1ns/1ps

module stepgen import motion_pkg::*; #(
    parameter int PULSE_LEN = 108,
    parameter int DIR_DELAY = 18,
    parameter int ACC_BITS  = 24
) (
    input  logic      sysclk,
    input  logic      arst_n,
    input  velocity_t velocity,
    input  logic      enable,
    output logic      step,
    output logic      dir,
    output logic      en,
    output position_t position
);

    localparam int TMR_MAX  = (PULSE_LEN > DIR_DELAY) ? PULSE_LEN : DIR_DELAY;
    localparam int TMR_BITS = $clog2(TMR_MAX + 1);

    dir_state_e          state;
    dir_state_e          state_n;
    logic [TMR_BITS-1:0] timer;
    logic [TMR_BITS-1:0] timer_n;
    logic [ACC_BITS-1:0] acc;
    logic [31:0]         mag;
    logic [32:0]         acc_sum;
    logic                vel_neg;
    logic                step_req;
    logic                pending;
    logic                pending_n;
    logic                dir_n;
    logic                launch;
    logic                start_pulse;

    // Dir high means counting down
    assign vel_neg  = velocity[31];
    assign mag      = vel_neg ? unsigned'(-velocity) : unsigned'(velocity);
    assign acc_sum  = 33'(acc) + 33'(mag);
    assign step_req = enable & (|acc_sum[32:ACC_BITS]);

    always_comb begin
        state_n     = state;
        timer_n     = timer;
        pending_n   = pending;
        dir_n       = dir;
        launch      = 1'b0;
        start_pulse = 1'b0;
        case (state)
            IDLE: launch = step_req;
            DIR_SETUP: begin
                // Setup time always runs out, even if disabled meanwhile
                pending_n = pending | step_req;
                if (timer != '0) begin
                    timer_n = timer - 1'b1;
                end else if (enable) begin
                    start_pulse = 1'b1;
                end else begin
                    state_n = IDLE;
                end
            end
            PULSE: begin
                pending_n = pending | step_req;
                if (timer != '0) begin
                    timer_n = timer - 1'b1;
                end else begin
                    state_n = SPACE;
                    timer_n = TMR_BITS'(PULSE_LEN - 1);
                end
            end
            SPACE: begin
                if (timer != '0) begin
                    pending_n = pending | step_req;
                    timer_n   = timer - 1'b1;
                end else begin
                    // Take one request, a second one stays pending
                    launch    = enable & (pending | step_req);
                    pending_n = pending & step_req;
                    state_n   = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
        if (launch) begin
            if (vel_neg != dir) begin
                dir_n   = vel_neg;
                state_n = DIR_SETUP;
                timer_n = TMR_BITS'(DIR_DELAY - 1);
            end else begin
                start_pulse = 1'b1;
            end
        end
        if (start_pulse) begin
            state_n = PULSE;
            timer_n = TMR_BITS'(PULSE_LEN - 1);
        end
        // Requests not yet started are dropped when disabled
        if (!enable) begin
            pending_n = 1'b0;
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            timer    <= '0;
            pending  <= 1'b0;
            dir      <= 1'b0;
            step     <= 1'b0;
            en       <= 1'b0;
            acc      <= '0;
            position <= '0;
        end else begin
            state   <= state_n;
            timer   <= timer_n;
            pending <= pending_n;
            dir     <= dir_n;
            step    <= (state_n == PULSE);
            en      <= enable;
            if (enable) begin
                acc <= acc_sum[ACC_BITS-1:0];
            end
            // Count on the rising step edge
            if (start_pulse) begin
                position <= dir ? position - position_t'(1) : position + position_t'(1);
            end
        end
    end

endmodule

//--- input_sync.sv
// Home switch input conditioning.
// Two flops per bit against metastability; switches are active low,
// so the bits are inverted on the way in.
`timescale 1ns/1ps

module input_sync import motion_pkg::*; (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic [NUM_AXES-1:0] home,
    output logic [NUM_AXES-1:0] inputs
);

    logic [NUM_AXES-1:0] meta;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            meta   <= '0;
            inputs <= '0;
        end else begin
            meta   <= ~home;
            inputs <= meta;
        end
    end

endmodule

//--- rio.sv
// Top level of the remote I/O controller.
// Host registers, link watchdog, home inputs and one step generator
// per axis; a link timeout disables every axis.
`timescale 1ns/1ps

module rio import rio_pkg::*, motion_pkg::*; #(
    parameter int TIMEOUT   = 2700000,
    parameter int PULSE_LEN = 108,
    parameter int DIR_DELAY = 18,
    parameter int ACC_BITS  = 24
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  reg_addr_t           awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  reg_word_t           wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  reg_addr_t           araddr,
    input  logic                arvalid,
    output logic                arready,
    output reg_word_t           rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    output logic [NUM_AXES-1:0] step,
    output logic [NUM_AXES-1:0] dir,
    output logic [NUM_AXES-1:0] en,
    input  logic [NUM_AXES-1:0] home,
    output logic                out_bit,
    output logic                timeout
);

    velocity_t           vel [NUM_AXES];
    position_t           pos [NUM_AXES];
    logic [NUM_AXES-1:0] axis_en;
    logic [NUM_AXES-1:0] axis_gated;
    logic [NUM_AXES-1:0] inputs;
    logic                commit;
    reg_word_t           tstamp;

    // Lost link stops all axes
    assign axis_gated = axis_en & ~{NUM_AXES{timeout}};

    host_regs regs (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .tstamp  (tstamp),
        .pos0    (pos[0]),
        .pos1    (pos[1]),
        .pos2    (pos[2]),
        .inputs  (inputs),
        .timeout (timeout),
        .vel0    (vel[0]),
        .vel1    (vel[1]),
        .vel2    (vel[2]),
        .axis_en (axis_en),
        .out_bit (out_bit),
        .commit  (commit)
    );

    link_watchdog #(
        .TIMEOUT (TIMEOUT)
    ) wdog (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .commit  (commit),
        .timeout (timeout),
        .tstamp  (tstamp)
    );

    input_sync home_sync (
        .sysclk (sysclk),
        .arst_n (arst_n),
        .home   (home),
        .inputs (inputs)
    );

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        stepgen #(
            .PULSE_LEN (PULSE_LEN),
            .DIR_DELAY (DIR_DELAY),
            .ACC_BITS  (ACC_BITS)
        ) gen (
            .sysclk   (sysclk),
            .arst_n   (arst_n),
            .velocity (vel[i]),
            .enable   (axis_gated[i]),
            .step     (step[i]),
            .dir      (dir[i]),
            .en       (en[i]),
            .position (pos[i])
        );
    end

endmodule

//--- rio_properties.sv
// Concurrent checks on the step pins, the watchdog and the AXI responses.
// Bound into rio by the testbench.
`timescale 1ns/1ps

module rio_properties import motion_pkg::*; #(
    parameter int PULSE_LEN = 108,
    parameter int DIR_DELAY = 18
) (
    input logic                sysclk,
    input logic                arst_n,
    input logic [NUM_AXES-1:0] step,
    input logic [NUM_AXES-1:0] dir,
    input logic [NUM_AXES-1:0] en,
    input logic                timeout,
    input logic                bvalid,
    input logic                bready,
    input logic                rvalid,
    input logic                rready
);

    int unsigned to_cnt;

    // Cycles since the timeout rose
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            to_cnt <= 0;
        end else begin
            to_cnt <= timeout ? to_cnt + 1 : 0;
        end
    end

    assert property (@(posedge sysclk) disable iff (!arst_n) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    assert property (@(posedge sysclk) disable iff (!arst_n) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        int unsigned high_cnt;
        int unsigned dir_age;
        logic        dir_prev;

        always_ff @(posedge sysclk or negedge arst_n) begin
            if (!arst_n) begin
                high_cnt <= 0;
                dir_age  <= DIR_DELAY;
                dir_prev <= 1'b0;
            end else begin
                high_cnt <= step[i] ? high_cnt + 1 : 0;
                dir_prev <= dir[i];
                if (dir[i] != dir_prev) begin
                    dir_age <= 1;
                end else if (dir_age < DIR_DELAY) begin
                    dir_age <= dir_age + 1;
                end
            end
        end

        assert property (@(posedge sysclk) disable iff (!arst_n)
            $fell(step[i]) |-> high_cnt == PULSE_LEN)
            else $error("step pulse on axis %0d has wrong width", i);
        assert property (@(posedge sysclk) disable iff (!arst_n)
            step[i] |-> high_cnt < PULSE_LEN)
            else $error("step on axis %0d high too long", i);
        assert property (@(posedge sysclk) disable iff (!arst_n)
            $rose(step[i]) |-> dir_age >= DIR_DELAY)
            else $error("dir setup too short on axis %0d", i);
        assert property (@(posedge sysclk) disable iff (!arst_n)
            step[i] |-> dir[i] == dir_prev)
            else $error("dir changed during step on axis %0d", i);
        assert property (@(posedge sysclk) disable iff (!arst_n)
            $rose(step[i]) |-> en[i])
            else $error("step on axis %0d while disabled", i);
        assert property (@(posedge sysclk) disable iff (!arst_n)
            $rose(step[i]) && timeout |-> to_cnt <= PULSE_LEN)
            else $error("step on axis %0d long after timeout", i);
    end

endmodule

//--- tb_clock.sv
// Clock and reset source for the testbench.
// 20 ns clock period, reset held low for the first two cycles.
`timescale 1ns/1ps

module tb_clock (
    output logic sysclk,
    output logic arst_n
);

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge sysclk);
        #2 arst_n = 1'b1;
    end

endmodule

//--- rio_tb.sv
// Testbench for the remote I/O controller.
// Drives the AXI4-Lite port and home pins, follows the step pins
// and compares read-back values against a model of the register rules.
`timescale 1ns/1ps

module rio_tb import rio_pkg::*, motion_pkg::*;;

    localparam int TIMEOUT     = 400;
    localparam int PULSE_LEN   = 4;
    localparam int DIR_DELAY   = 3;
    localparam int CYCLE_LIMIT = 6000;

    logic                sysclk;
    logic                arst_n;
    reg_addr_t           awaddr;
    logic                awvalid;
    logic                awready;
    reg_word_t           wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    reg_addr_t           araddr;
    logic                arvalid;
    logic                arready;
    reg_word_t           rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    logic [NUM_AXES-1:0] step;
    logic [NUM_AXES-1:0] dir;
    logic [NUM_AXES-1:0] en;
    logic [NUM_AXES-1:0] home;
    logic [NUM_AXES-1:0] step_q;
    logic                out_bit;
    logic                timeout;

    logic [31:0] lfsr = 32'hce16_0cb1;
    int cycles = 0;
    int errs = 0;
    int errs_at_start = 0;
    int tests_run = 0;
    int tests_ok = 0;
    int rises [NUM_AXES];
    position_t pos_model [NUM_AXES];

    tb_clock clk_gen (.sysclk(sysclk), .arst_n(arst_n));

    rio #(
        .TIMEOUT(TIMEOUT), .PULSE_LEN(PULSE_LEN), .DIR_DELAY(DIR_DELAY), .ACC_BITS(8)
    ) UUT (.*);

    bind rio rio_properties #(.PULSE_LEN(PULSE_LEN), .DIR_DELAY(DIR_DELAY)) props (
        .sysclk(sysclk), .arst_n(arst_n), .step(step), .dir(dir), .en(en),
        .timeout(timeout), .bvalid(bvalid), .bready(bready),
        .rvalid(rvalid), .rready(rready)
    );

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // Signed step count seen on the pins
    always @(negedge sysclk) begin
        for (int i = 0; i < NUM_AXES; i++) begin
            if (arst_n && step[i] && !step_q[i]) begin
                rises[i]++;
                pos_model[i] += dir[i] ? -1 : 1;
            end
        end
        step_q = step;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA300_0000 : lfsr >> 1;
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic rand_velocity(input logic neg, output reg_word_t v);
        logic [31:0] m;
        m = take_bits(6);
        m = 16 + (m % 48);
        v = neg ? -m : m;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    task automatic axi_write(input reg_addr_t addr, input reg_word_t data,
                             output logic [1:0] resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge sysclk);
        while (!awready) @(negedge sysclk);
        check_eq("wready", wready, 1'b1);
        @(posedge sysclk);
        #2 awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        @(negedge sysclk);
        while (!bvalid) @(negedge sysclk);
        resp = bresp;
        @(posedge sysclk);
        #2 bready = 1'b0;
    endtask

    task automatic axi_read(input reg_addr_t addr, output reg_word_t data,
                            output logic [1:0] resp);
        araddr = addr;
        arvalid = 1'b1;
        @(negedge sysclk);
        while (!arready) @(negedge sysclk);
        @(posedge sysclk);
        #2 arvalid = 1'b0;
        rready = 1'b1;
        @(negedge sysclk);
        while (!rvalid) @(negedge sysclk);
        data = rdata;
        resp = rresp;
        @(posedge sysclk);
        #2 rready = 1'b0;
    endtask

    task automatic check_eq(input string name, input reg_word_t got, input reg_word_t exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("Error at %0t: %s", $time, what);
            errs++;
        end
    endtask

    task automatic start_test();
        errs_at_start = errs;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errs == errs_at_start) begin
            tests_ok++;
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_run, name, errs - errs_at_start);
        end
    endtask

    // Writes CTRL and random velocities, then commits
    task automatic command(input reg_word_t ctrl, input logic neg);
        reg_word_t v;
        logic [1:0] r;
        axi_write(ADDR_CTRL, ctrl, r);
        for (int i = 0; i < NUM_AXES; i++) begin
            rand_velocity(neg, v);
            axi_write(reg_addr_t'(ADDR_VEL0 + 4 * i), v, r);
        end
        axi_write(ADDR_COMMIT, 32'h0, r);
    endtask

    initial begin
        reg_word_t d;
        reg_word_t t0;
        logic [1:0] r;
        logic [31:0] pat;
        logic [NUM_AXES-1:0] exp_home;
        int base [NUM_AXES];
        int n;
        awaddr = '0;
        wdata = '0;
        wstrb = 4'hF;
        awvalid = 0;
        wvalid = 0;
        bready = 0;
        araddr = '0;
        arvalid = 0;
        rready = 0;
        home = 3'b111;
        step_q = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            rises[i] = 0;
            pos_model[i] = '0;
        end
        @(posedge arst_n);
        wait_cycles(1);

        start_test();
        axi_read(ADDR_MAGIC, d, r);
        check_eq("rdata", d, MAGIC_WORD);
        check_eq("rresp", r, AXI_RESP_OKAY);
        axi_read(ADDR_TSTAMP, t0, r);
        axi_read(ADDR_TSTAMP, d, r);
        check_true(d > t0, "timestamp did not increase between reads");
        axi_read(8'h40, d, r);
        check_eq("rdata", d, 32'h0);
        check_eq("rresp", r, AXI_RESP_SLVERR);
        axi_write(8'h44, 32'h1234, r);
        check_eq("bresp", r, AXI_RESP_SLVERR);
        end_test("register access");

        start_test();
        axi_write(ADDR_CTRL, 32'hB, r);
        for (int i = 0; i < NUM_AXES; i++) begin
            rand_velocity(1'b0, d);
            axi_write(reg_addr_t'(ADDR_VEL0 + 4 * i), d, r);
        end
        wait_cycles(30);
        check_eq("rises", rises[0] + rises[1] + rises[2], 0);
        check_eq("out_bit", out_bit, 1'b0);
        axi_write(ADDR_COMMIT, 32'h0, r);
        check_eq("out_bit", out_bit, 1'b1);
        for (int i = 0; i < NUM_AXES; i++) begin
            base[i] = rises[i];
        end
        wait_cycles(150);
        check_true(rises[0] > base[0], "no steps on enabled axis 0");
        check_true(rises[1] > base[1], "no steps on enabled axis 1");
        check_eq("rises[2]", rises[2], 0);
        end_test("commit semantics");

        start_test();
        command(32'h7, 1'b1);
        wait_cycles(150);
        command(32'h7, 1'b0);
        wait_cycles(100);
        end_test("step rules");

        start_test();
        command(32'h7, 1'b1);
        wait_cycles(120);
        axi_write(ADDR_CTRL, 32'h0, r);
        axi_write(ADDR_COMMIT, 32'h0, r);
        n = 0;
        while ((en != '0 || step != '0) && n < 50) begin
            wait_cycles(1);
            n++;
        end
        check_true(n < 50, "axes did not stop after disable");
        wait_cycles(2);
        for (int i = 0; i < NUM_AXES; i++) begin
            axi_read(reg_addr_t'(ADDR_POS0 + 4 * i), d, r);
            check_eq($sformatf("pos%0d", i), d, reg_word_t'(pos_model[i]));
        end
        end_test("position tracking");

        start_test();
        command(32'h7, 1'b0);
        n = 0;
        while (!timeout && n < TIMEOUT + 50) begin
            wait_cycles(1);
            n++;
        end
        check_true(timeout, "timeout pin did not rise");
        wait_cycles(2);
        check_eq("en", en, 3'b000);
        axi_read(ADDR_STATUS, d, r);
        check_eq("status[4]", d[STATUS_TIMEOUT_BIT], 1'b1);
        axi_write(ADDR_CTRL, 32'h0, r);
        axi_write(ADDR_COMMIT, 32'h0, r);
        check_eq("timeout", timeout, 1'b0);
        axi_read(ADDR_STATUS, d, r);
        check_eq("status[4]", d[STATUS_TIMEOUT_BIT], 1'b0);
        end_test("watchdog");

        start_test();
        for (int k = 0; k < 4; k++) begin
            pat = take_bits(3);
            home = pat[2:0];
            // Switches are active low
            exp_home = ~pat[2:0];
            wait_cycles(2);
            axi_read(ADDR_STATUS, d, r);
            check_eq("status[2:0]", d[2:0], exp_home);
        end
        end_test("inputs");

        $display("%0d of %0d tests ok, %0d checks failed", tests_ok, tests_run, errs);
        if (errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- rio.f
rio_pkg.sv
motion_pkg.sv
host_regs.sv
link_watchdog.sv
stepgen.sv
input_sync.sv
rio.sv
rio_properties.sv
tb_clock.sv
rio_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f rio.f --top-module rio_tb -o rio_sim
	@out=$$(./obj_dir/rio_sim); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
